// File: logic/iq_pkg.sv
package iq_pkg;

   // physical register tag and reorder-buffer id
   typedef logic [5:0] prf_tag_t;
   typedef logic [5:0] rob_id_t;

   // operation class, decides which execution slot may take it
   typedef logic [1:0] op_class_t;

   localparam op_class_t OP_ALU = 2'd0;  // either slot
   localparam op_class_t OP_BJU = 2'd1;  // slot 1 only
   localparam op_class_t OP_MUL = 2'd2;  // slot 0 only

   // saturating age counter per entry
   localparam int AGE_WIDTH = 4;

endpackage

// File: logic/iq_ifs.sv
`timescale 1ns/1ps

// two free entries for the dispatcher
interface alloc_if #(parameter int QUEUE_DEPTH = 8);
   localparam int IDX_W = $clog2(QUEUE_DEPTH);

   logic [IDX_W-1:0] alloc0_id;
   logic             alloc0_ok;
   logic [IDX_W-1:0] alloc1_id;
   logic             alloc1_ok;

   modport source (output alloc0_id, alloc0_ok, alloc1_id, alloc1_ok);
   modport sink   (input  alloc0_id, alloc0_ok, alloc1_id, alloc1_ok);
endinterface

// the two oldest ready entries, old0 never younger than old1
interface pick_if #(parameter int QUEUE_DEPTH = 8);
   localparam int IDX_W = $clog2(QUEUE_DEPTH);

   logic [IDX_W-1:0]  old0_id;
   logic              old0_valid;
   logic [IDX_W-1:0]  old1_id;
   logic              old1_valid;
   iq_pkg::op_class_t old0_class;  // looked up by the entry array
   iq_pkg::op_class_t old1_class;

   modport picker    (output old0_id, old0_valid, old1_id, old1_valid);
   modport class_src (input old0_id, old1_id, output old0_class, old1_class);
   modport sink      (input old0_id, old0_valid, old1_id, old1_valid,
                      old0_class, old1_class);
endinterface

interface issue_if #(parameter int QUEUE_DEPTH = 8);
   localparam int IDX_W = $clog2(QUEUE_DEPTH);

   logic             slot0_fire;
   logic [IDX_W-1:0] slot0_id;
   logic             slot1_fire;
   logic [IDX_W-1:0] slot1_id;

   modport source (output slot0_fire, slot0_id, slot1_fire, slot1_id);
   modport sink   (input  slot0_fire, slot0_id, slot1_fire, slot1_id);
endinterface

// File: logic/free_slot_finder.sv
`timescale 1ns/1ps

module free_slot_finder #(
   parameter int QUEUE_DEPTH = 8
) (
   input  logic [QUEUE_DEPTH-1:0] entry_valid,
   alloc_if.source                alloc
);

   localparam int IDX_W = $clog2(QUEUE_DEPTH);

   // lowest free index first, then the next one up
   always_comb begin
      logic             found0;
      logic             found1;
      logic [IDX_W-1:0] id0;
      logic [IDX_W-1:0] id1;

      found0 = 1'b0;
      found1 = 1'b0;
      id0    = '0;
      id1    = '0;
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         if (!entry_valid[i]) begin
            if (!found0) begin
               found0 = 1'b1;
               id0    = IDX_W'(i);
            end else if (!found1) begin
               found1 = 1'b1;
               id1    = IDX_W'(i);
            end
         end
      end

      alloc.alloc0_id = id0;
      alloc.alloc0_ok = found0;
      alloc.alloc1_id = id1;
      alloc.alloc1_ok = found1;
   end

endmodule

// File: logic/entry_array.sv
`timescale 1ns/1ps

module entry_array #(
   parameter int QUEUE_DEPTH = 8
) (
   input  logic                   clk,
   input  logic                   reset_n,
   input  logic                   enq0_valid,
   input  iq_pkg::op_class_t      enq0_class,
   input  iq_pkg::rob_id_t        enq0_robid,
   input  iq_pkg::prf_tag_t       enq0_src1,
   input  iq_pkg::prf_tag_t       enq0_src2,
   input  logic                   enq0_src1_busy,
   input  logic                   enq0_src2_busy,
   input  iq_pkg::prf_tag_t       enq0_dest,
   input  logic                   enq1_valid,
   input  iq_pkg::op_class_t      enq1_class,
   input  iq_pkg::rob_id_t        enq1_robid,
   input  iq_pkg::prf_tag_t       enq1_src1,
   input  iq_pkg::prf_tag_t       enq1_src2,
   input  logic                   enq1_src1_busy,
   input  logic                   enq1_src2_busy,
   input  iq_pkg::prf_tag_t       enq1_dest,
   input  logic                   wb0_valid,
   input  iq_pkg::prf_tag_t       wb0_tag,
   input  logic                   wb1_valid,
   input  iq_pkg::prf_tag_t       wb1_tag,
   alloc_if.sink                  alloc,
   issue_if.sink                  issue,
   pick_if.class_src              pick,
   output logic [QUEUE_DEPTH-1:0] entry_valid,
   output logic [QUEUE_DEPTH-1:0] entry_ready,
   output iq_pkg::op_class_t      slot0_class,
   output iq_pkg::op_class_t      slot1_class,
   output iq_pkg::rob_id_t        slot0_robid,
   output iq_pkg::rob_id_t        slot1_robid,
   output iq_pkg::prf_tag_t       slot0_dest,
   output iq_pkg::prf_tag_t       slot1_dest
);

   localparam int IDX_W = $clog2(QUEUE_DEPTH);

   logic [QUEUE_DEPTH-1:0] valid_q;
   logic [QUEUE_DEPTH-1:0] busy1_q;
   logic [QUEUE_DEPTH-1:0] busy2_q;
   iq_pkg::op_class_t      class_q [QUEUE_DEPTH];
   iq_pkg::rob_id_t        robid_q [QUEUE_DEPTH];
   iq_pkg::prf_tag_t       src1_q  [QUEUE_DEPTH];
   iq_pkg::prf_tag_t       src2_q  [QUEUE_DEPTH];
   iq_pkg::prf_tag_t       dest_q  [QUEUE_DEPTH];

   logic [IDX_W-1:0] enq0_idx;
   logic [IDX_W-1:0] enq1_idx;
   logic             enq0_wr;
   logic             enq1_wr;

   // a lone enq1 takes the first free entry
   assign enq0_idx = alloc.alloc0_id;
   assign enq1_idx = enq0_valid ? alloc.alloc1_id : alloc.alloc0_id;
   assign enq0_wr  = enq0_valid && alloc.alloc0_ok;
   assign enq1_wr  = enq1_valid && (enq0_valid ? alloc.alloc1_ok : alloc.alloc0_ok);

   function automatic logic wb_hit(input iq_pkg::prf_tag_t tag,
                                   input logic             v0,
                                   input iq_pkg::prf_tag_t t0,
                                   input logic             v1,
                                   input iq_pkg::prf_tag_t t1);
      return (v0 && (t0 == tag)) || (v1 && (t1 == tag));
   endfunction

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         valid_q <= '0;
      end else begin
         if (issue.slot0_fire) valid_q[issue.slot0_id] <= 1'b0;
         if (issue.slot1_fire) valid_q[issue.slot1_id] <= 1'b0;
         if (enq0_wr) valid_q[enq0_idx] <= 1'b1;
         if (enq1_wr) valid_q[enq1_idx] <= 1'b1;
      end
   end

   // payload, both enqueues write every field
   always_ff @(posedge clk) begin
      if (enq0_wr) begin
         class_q[enq0_idx] <= enq0_class;
         robid_q[enq0_idx] <= enq0_robid;
         src1_q[enq0_idx]  <= enq0_src1;
         src2_q[enq0_idx]  <= enq0_src2;
         dest_q[enq0_idx]  <= enq0_dest;
      end
      if (enq1_wr) begin
         class_q[enq1_idx] <= enq1_class;
         robid_q[enq1_idx] <= enq1_robid;
         src1_q[enq1_idx]  <= enq1_src1;
         src2_q[enq1_idx]  <= enq1_src2;
         dest_q[enq1_idx]  <= enq1_dest;
      end
   end

   // wakeup runs every cycle, enqueue or not
   always_ff @(posedge clk) begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         if (valid_q[i] && wb_hit(src1_q[i], wb0_valid, wb0_tag, wb1_valid, wb1_tag))
            busy1_q[i] <= 1'b0;
         if (valid_q[i] && wb_hit(src2_q[i], wb0_valid, wb0_tag, wb1_valid, wb1_tag))
            busy2_q[i] <= 1'b0;
      end
      // same-cycle writeback bypasses into the new entry
      if (enq0_wr) begin
         busy1_q[enq0_idx] <= enq0_src1_busy &&
                              !wb_hit(enq0_src1, wb0_valid, wb0_tag, wb1_valid, wb1_tag);
         busy2_q[enq0_idx] <= enq0_src2_busy &&
                              !wb_hit(enq0_src2, wb0_valid, wb0_tag, wb1_valid, wb1_tag);
      end
      if (enq1_wr) begin
         busy1_q[enq1_idx] <= enq1_src1_busy &&
                              !wb_hit(enq1_src1, wb0_valid, wb0_tag, wb1_valid, wb1_tag);
         busy2_q[enq1_idx] <= enq1_src2_busy &&
                              !wb_hit(enq1_src2, wb0_valid, wb0_tag, wb1_valid, wb1_tag);
      end
   end

   assign entry_valid = valid_q;
   assign entry_ready = valid_q & ~busy1_q & ~busy2_q;

   assign pick.old0_class = class_q[pick.old0_id];  // steering needs the class
   assign pick.old1_class = class_q[pick.old1_id];

   assign slot0_class = class_q[issue.slot0_id];
   assign slot1_class = class_q[issue.slot1_id];
   assign slot0_robid = robid_q[issue.slot0_id];
   assign slot1_robid = robid_q[issue.slot1_id];
   assign slot0_dest  = dest_q[issue.slot0_id];
   assign slot1_dest  = dest_q[issue.slot1_id];

endmodule

// File: logic/age_tracker.sv
`timescale 1ns/1ps

module age_tracker #(
   parameter int QUEUE_DEPTH = 8
) (
   input  logic                        clk,
   input  logic                        reset_n,
   input  logic                        enq0_valid,
   input  logic                        enq1_valid,
   alloc_if.sink                       alloc,
   issue_if.sink                       issue,
   output logic [iq_pkg::AGE_WIDTH-1:0] entry_age [QUEUE_DEPTH]
);

   localparam int IDX_W = $clog2(QUEUE_DEPTH);
   localparam int AGE_W = iq_pkg::AGE_WIDTH;

   logic [AGE_W-1:0] age_q [QUEUE_DEPTH];
   logic [AGE_W-1:0] age_d [QUEUE_DEPTH];
   logic [IDX_W-1:0] enq0_idx;
   logic [IDX_W-1:0] enq1_idx;
   logic             enq0_wr;
   logic             enq1_wr;
   logic [1:0]       n_new;

   assign enq0_idx = alloc.alloc0_id;
   assign enq1_idx = enq0_valid ? alloc.alloc1_id : alloc.alloc0_id;
   assign enq0_wr  = enq0_valid && alloc.alloc0_ok;
   assign enq1_wr  = enq1_valid && (enq0_valid ? alloc.alloc1_ok : alloc.alloc0_ok);
   assign n_new    = {1'b0, enq0_wr} + {1'b0, enq1_wr};

   always_comb begin
      logic [AGE_W:0] sum;

      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         sum      = {1'b0, age_q[i]} + {{(AGE_W-1){1'b0}}, n_new};
         age_d[i] = sum[AGE_W] ? '1 : sum[AGE_W-1:0];  // saturate
      end
      // enq0 is older than enq1 in the same cycle
      if (enq0_wr) age_d[enq0_idx] = enq1_wr ? AGE_W'(1) : '0;
      if (enq1_wr) age_d[enq1_idx] = '0;
      if (issue.slot0_fire) age_d[issue.slot0_id] = '0;
      if (issue.slot1_fire) age_d[issue.slot1_id] = '0;
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int i = 0; i < QUEUE_DEPTH; i++)
            age_q[i] <= '0;
      end else begin
         age_q <= age_d;
      end
   end

   assign entry_age = age_q;

endmodule

// File: logic/oldest_picker.sv
`timescale 1ns/1ps

module oldest_picker #(
   parameter int QUEUE_DEPTH = 8
) (
   input  logic [QUEUE_DEPTH-1:0]       entry_ready,
   input  logic [iq_pkg::AGE_WIDTH-1:0] entry_age [QUEUE_DEPTH],
   pick_if.picker                       pick
);

   localparam int IDX_W = $clog2(QUEUE_DEPTH);
   localparam int AGE_W = iq_pkg::AGE_WIDTH;

   always_comb begin
      logic             found0;
      logic             found1;
      logic [IDX_W-1:0] id0;
      logic [IDX_W-1:0] id1;
      logic [AGE_W-1:0] age0;
      logic [AGE_W-1:0] age1;

      found0 = 1'b0;
      found1 = 1'b0;
      id0    = '0;
      id1    = '0;
      age0   = '0;
      age1   = '0;

      // strict compare keeps the lower index on a tie
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         if (entry_ready[i] && (!found0 || entry_age[i] > age0)) begin
            found0 = 1'b1;
            id0    = IDX_W'(i);
            age0   = entry_age[i];
         end
      end

      // best of the rest
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         if (entry_ready[i] && (IDX_W'(i) != id0) &&
             (!found1 || entry_age[i] > age1)) begin
            found1 = 1'b1;
            id1    = IDX_W'(i);
            age1   = entry_age[i];
         end
      end

      pick.old0_id    = id0;
      pick.old0_valid = found0;
      pick.old1_id    = id1;
      pick.old1_valid = found1;
   end

endmodule

// File: logic/slot_steer.sv
`timescale 1ns/1ps

module slot_steer #(
   parameter int QUEUE_DEPTH = 8
) (
   input  logic       clk,
   input  logic       reset_n,
   input  logic       mul_busy,
   pick_if.sink       pick,
   issue_if.source    issue,
   output logic       slot0_valid,
   output logic       slot1_valid,
   output logic [1:0] credit_return
);

   localparam int IDX_W = $clog2(QUEUE_DEPTH);

   logic is_mul0;
   logic is_mul1;
   logic is_bju0;
   logic is_bju1;
   logic elig0;
   logic elig1;

   assign is_mul0 = pick.old0_class == iq_pkg::OP_MUL;
   assign is_mul1 = pick.old1_class == iq_pkg::OP_MUL;
   assign is_bju0 = pick.old0_class == iq_pkg::OP_BJU;
   assign is_bju1 = pick.old1_class == iq_pkg::OP_BJU;

   // a multiply held by mul_busy sits out, the other pick may still go
   assign elig0 = pick.old0_valid && !(is_mul0 && mul_busy);
   assign elig1 = pick.old1_valid && !(is_mul1 && mul_busy);

   always_comb begin
      logic             s0_fire;
      logic             s1_fire;
      logic [IDX_W-1:0] s0_id;
      logic [IDX_W-1:0] s1_id;

      s0_fire = 1'b0;
      s1_fire = 1'b0;
      s0_id   = pick.old0_id;
      s1_id   = pick.old1_id;

      // older pick first
      if (elig0) begin
         if (is_bju0) begin
            s1_fire = 1'b1;
            s1_id   = pick.old0_id;
         end else if (is_mul0 || !(elig1 && is_mul1)) begin
            s0_fire = 1'b1;
            s0_id   = pick.old0_id;
         end else begin
            s1_fire = 1'b1;  // alu leaves slot 0 to the multiply
            s1_id   = pick.old0_id;
         end
      end

      // younger pick takes what is left
      if (elig1) begin
         if (is_mul1) begin
            if (!s0_fire) begin
               s0_fire = 1'b1;
               s0_id   = pick.old1_id;
            end
         end else if (is_bju1) begin
            if (!s1_fire) begin
               s1_fire = 1'b1;
               s1_id   = pick.old1_id;
            end
         end else if (!s0_fire) begin
            s0_fire = 1'b1;
            s0_id   = pick.old1_id;
         end else if (!s1_fire) begin
            s1_fire = 1'b1;
            s1_id   = pick.old1_id;
         end
      end

      issue.slot0_fire = s0_fire;
      issue.slot0_id   = s0_id;
      issue.slot1_fire = s1_fire;
      issue.slot1_id   = s1_id;
   end

   assign slot0_valid = issue.slot0_fire;
   assign slot1_valid = issue.slot1_fire;

   // one credit back per issued instruction, a cycle later
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         credit_return <= 2'd0;
      end else begin
         credit_return <= {1'b0, issue.slot0_fire} + {1'b0, issue.slot1_fire};
      end
   end

endmodule

// File: logic/issue_queue_top.sv
`timescale 1ns/1ps

module issue_queue_top #(
   parameter int QUEUE_DEPTH = 8
) (
   input  logic              clk,
   input  logic              reset_n,
   input  logic              enq0_valid,
   input  iq_pkg::op_class_t enq0_class,
   input  iq_pkg::rob_id_t   enq0_robid,
   input  iq_pkg::prf_tag_t  enq0_src1,
   input  iq_pkg::prf_tag_t  enq0_src2,
   input  logic              enq0_src1_busy,
   input  logic              enq0_src2_busy,
   input  iq_pkg::prf_tag_t  enq0_dest,
   input  logic              enq1_valid,
   input  iq_pkg::op_class_t enq1_class,
   input  iq_pkg::rob_id_t   enq1_robid,
   input  iq_pkg::prf_tag_t  enq1_src1,
   input  iq_pkg::prf_tag_t  enq1_src2,
   input  logic              enq1_src1_busy,
   input  logic              enq1_src2_busy,
   input  iq_pkg::prf_tag_t  enq1_dest,
   input  logic              wb0_valid,
   input  iq_pkg::prf_tag_t  wb0_tag,
   input  logic              wb1_valid,
   input  iq_pkg::prf_tag_t  wb1_tag,
   input  logic              mul_busy,
   output logic              slot0_valid,
   output iq_pkg::op_class_t slot0_class,
   output iq_pkg::rob_id_t   slot0_robid,
   output iq_pkg::prf_tag_t  slot0_dest,
   output logic              slot1_valid,
   output iq_pkg::op_class_t slot1_class,
   output iq_pkg::rob_id_t   slot1_robid,
   output iq_pkg::prf_tag_t  slot1_dest,
   output logic [1:0]        credit_return
);

   logic [QUEUE_DEPTH-1:0]       entry_valid;
   logic [QUEUE_DEPTH-1:0]       entry_ready;
   logic [iq_pkg::AGE_WIDTH-1:0] entry_age [QUEUE_DEPTH];

   alloc_if #(.QUEUE_DEPTH(QUEUE_DEPTH)) alloc_bus ();
   pick_if  #(.QUEUE_DEPTH(QUEUE_DEPTH)) pick_bus ();
   issue_if #(.QUEUE_DEPTH(QUEUE_DEPTH)) issue_bus ();

   free_slot_finder #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_free (
      .entry_valid (entry_valid),
      .alloc       (alloc_bus)
   );

   entry_array #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_entries (
      .clk            (clk),
      .reset_n        (reset_n),
      .enq0_valid     (enq0_valid),
      .enq0_class     (enq0_class),
      .enq0_robid     (enq0_robid),
      .enq0_src1      (enq0_src1),
      .enq0_src2      (enq0_src2),
      .enq0_src1_busy (enq0_src1_busy),
      .enq0_src2_busy (enq0_src2_busy),
      .enq0_dest      (enq0_dest),
      .enq1_valid     (enq1_valid),
      .enq1_class     (enq1_class),
      .enq1_robid     (enq1_robid),
      .enq1_src1      (enq1_src1),
      .enq1_src2      (enq1_src2),
      .enq1_src1_busy (enq1_src1_busy),
      .enq1_src2_busy (enq1_src2_busy),
      .enq1_dest      (enq1_dest),
      .wb0_valid      (wb0_valid),
      .wb0_tag        (wb0_tag),
      .wb1_valid      (wb1_valid),
      .wb1_tag        (wb1_tag),
      .alloc          (alloc_bus),
      .issue          (issue_bus),
      .pick           (pick_bus),
      .entry_valid    (entry_valid),
      .entry_ready    (entry_ready),
      .slot0_class    (slot0_class),
      .slot1_class    (slot1_class),
      .slot0_robid    (slot0_robid),
      .slot1_robid    (slot1_robid),
      .slot0_dest     (slot0_dest),
      .slot1_dest     (slot1_dest)
   );

   age_tracker #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_age (
      .clk        (clk),
      .reset_n    (reset_n),
      .enq0_valid (enq0_valid),
      .enq1_valid (enq1_valid),
      .alloc      (alloc_bus),
      .issue      (issue_bus),
      .entry_age  (entry_age)
   );

   oldest_picker #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_picker (
      .entry_ready (entry_ready),
      .entry_age   (entry_age),
      .pick        (pick_bus)
   );

   slot_steer #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_steer (
      .clk           (clk),
      .reset_n       (reset_n),
      .mul_busy      (mul_busy),
      .pick          (pick_bus),
      .issue         (issue_bus),
      .slot0_valid   (slot0_valid),
      .slot1_valid   (slot1_valid),
      .credit_return (credit_return)
   );

endmodule

// File: verif/issue_queue_properties.sv
`timescale 1ns/1ps

module issue_queue_properties (
   input logic              clk,
   input logic              reset_n,
   input logic              mul_busy,
   input logic              slot0_valid,
   input iq_pkg::op_class_t slot0_class,
   input iq_pkg::rob_id_t   slot0_robid,
   input logic              slot1_valid,
   input iq_pkg::op_class_t slot1_class,
   input iq_pkg::rob_id_t   slot1_robid,
   input logic [1:0]        credit_return
);

   int fail_count = 0;  // read by the testbench at the end

   // slot 0 has no branch unit
   slot0_no_bju: assert property (@(posedge clk) disable iff (!reset_n)
      slot0_valid |-> slot0_class != iq_pkg::OP_BJU)
      else begin
         fail_count++;
         $error("branch/jump issued on slot 0");
      end

   slot1_no_mul: assert property (@(posedge clk) disable iff (!reset_n)
      slot1_valid |-> slot1_class != iq_pkg::OP_MUL)
      else begin
         fail_count++;
         $error("multiply issued on slot 1");
      end

   mul_held: assert property (@(posedge clk) disable iff (!reset_n)
      (slot0_valid && slot0_class == iq_pkg::OP_MUL) |-> !mul_busy)
      else begin
         fail_count++;
         $error("multiply issued while the multiplier was busy");
      end

   slots_distinct: assert property (@(posedge clk) disable iff (!reset_n)
      (slot0_valid && slot1_valid) |-> slot0_robid != slot1_robid)
      else begin
         fail_count++;
         $error("both slots carry robid %h", slot0_robid);
      end

   // one credit per issue, one cycle later
   credit_match: assert property (@(posedge clk) disable iff (!reset_n)
      $past(reset_n) |-> credit_return == $past({1'b0, slot0_valid} + {1'b0, slot1_valid}))
      else begin
         fail_count++;
         $error("credit_return %h does not match the previous issues", credit_return);
      end

endmodule

bind issue_queue_top issue_queue_properties u_props (
   .clk           (clk),
   .reset_n       (reset_n),
   .mul_busy      (mul_busy),
   .slot0_valid   (slot0_valid),
   .slot0_class   (slot0_class),
   .slot0_robid   (slot0_robid),
   .slot1_valid   (slot1_valid),
   .slot1_class   (slot1_class),
   .slot1_robid   (slot1_robid),
   .credit_return (credit_return)
);

// File: verif/tb_issue_queue.sv
`timescale 1ns/1ps

module tb_issue_queue;

   localparam int QUEUE_DEPTH = 8;
   localparam int N_INSTR     = 200;
   localparam int TOTAL       = N_INSTR + 4;  // random phase plus the directed four
   localparam int CLK_HALF    = 4;

   logic clk;
   logic reset_n;
   logic enq0_valid, enq0_src1_busy, enq0_src2_busy;
   logic enq1_valid, enq1_src1_busy, enq1_src2_busy;
   iq_pkg::op_class_t enq0_class, enq1_class, slot0_class, slot1_class;
   iq_pkg::rob_id_t   enq0_robid, enq1_robid, slot0_robid, slot1_robid;
   iq_pkg::prf_tag_t  enq0_src1, enq0_src2, enq0_dest, enq1_src1, enq1_src2, enq1_dest;
   iq_pkg::prf_tag_t  wb0_tag, wb1_tag, slot0_dest, slot1_dest;
   logic wb0_valid, wb1_valid, mul_busy;
   logic slot0_valid, slot1_valid;
   logic [1:0] credit_return;

   // scoreboard and credit model
   int errors      = 0;
   int credits     = QUEUE_DEPTH;
   int returned    = 0;
   int enq_total   = 0;
   int issue_count = 0;
   int live        = 0;
   int cyc         = 0;   // posedge count
   int mul_left    = 0;
   bit directed    = 1'b0;
   iq_pkg::rob_id_t   next_rid = '0;
   bit                in_flight [64];
   iq_pkg::prf_tag_t  exp_dest [64];
   iq_pkg::op_class_t exp_class [64];
   bit                busy_has [64][2];
   iq_pkg::prf_tag_t  busy_tag [64][2];
   int                wb_at [64][2];  // edge at which each busy source got its writeback
   bit                tag_used [64];
   iq_pkg::prf_tag_t  pend_q [$];   // busy tags still waiting for writeback
   iq_pkg::rob_id_t   dir_exp [$];
   logic [6:0]        dir_log [$];  // {slot, robid}

   issue_queue_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) dut (.*);

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   function automatic iq_pkg::prf_tag_t fresh_tag();
      iq_pkg::prf_tag_t t;
      t = iq_pkg::prf_tag_t'($urandom_range(63, 0));
      while (tag_used[t])
         t = t + 1'b1;
      tag_used[t] = 1'b1;
      pend_q.push_back(t);
      return t;
   endfunction

   task automatic new_instr(input bit alu_ready,
                            output iq_pkg::op_class_t cls,
                            output iq_pkg::rob_id_t   rid,
                            output iq_pkg::prf_tag_t  s1,
                            output iq_pkg::prf_tag_t  s2,
                            output logic              b1,
                            output logic              b2,
                            output iq_pkg::prf_tag_t  dst);
      rid = next_rid;
      while (in_flight[rid])
         rid = rid + 1'b1;
      next_rid = rid + 1'b1;
      cls = alu_ready ? iq_pkg::OP_ALU : iq_pkg::op_class_t'($urandom_range(2, 0));
      b1  = !alu_ready && ($urandom_range(2, 0) == 0);
      b2  = !alu_ready && ($urandom_range(2, 0) == 0);
      s1  = b1 ? fresh_tag() : iq_pkg::prf_tag_t'($urandom_range(63, 0));
      s2  = b2 ? fresh_tag() : iq_pkg::prf_tag_t'($urandom_range(63, 0));
      dst = iq_pkg::prf_tag_t'($urandom_range(63, 0));
      in_flight[rid]   = 1'b1;
      exp_dest[rid]    = dst;
      exp_class[rid]   = cls;
      busy_has[rid][0] = b1;
      busy_has[rid][1] = b2;
      busy_tag[rid][0] = s1;
      busy_tag[rid][1] = s2;
      wb_at[rid][0]    = -1;
      wb_at[rid][1]    = -1;
      credits--;
      enq_total++;
      live++;
      if (directed)
         dir_exp.push_back(rid);
   endtask

   task automatic drive_wb(output logic v, output iq_pkg::prf_tag_t tag);
      int i;
      v   = 1'b0;
      tag = '0;
      if (pend_q.size() > 0 && $urandom_range(2, 0) == 0) begin
         i   = $urandom_range(pend_q.size() - 1, 0);
         tag = pend_q[i];
         pend_q.delete(i);
         tag_used[tag] = 1'b0;
         // the one source still waiting on this tag, taken at the coming edge
         for (int r = 0; r < 64; r++)
            for (int s = 0; s < 2; s++)
               if (in_flight[r] && busy_has[r][s] && busy_tag[r][s] == tag &&
                   wb_at[r][s] < 0)
                  wb_at[r][s] = cyc + 1;
         v = 1'b1;
      end
   endtask

   // falling edge, collect credits and clear the strobes
   task automatic step();
      @(negedge clk);
      credits  += credit_return;
      returned += credit_return;
      assert (credits <= QUEUE_DEPTH) else begin
         errors++;
         $display("credits exceed the queue depth, %0d held", credits);
      end
      enq0_valid = 1'b0;
      enq1_valid = 1'b0;
      wb0_valid  = 1'b0;
      wb1_valid  = 1'b0;
   endtask

   task automatic random_cycle(input bit allow_enq);
      int n;
      bit lane;
      step();
      n = allow_enq ? $urandom_range(2, 0) : 0;
      if (n > credits)
         n = credits;
      if (n > TOTAL - enq_total)
         n = TOTAL - enq_total;
      lane = $urandom_range(1, 0);
      if (n == 2 || (n == 1 && !lane)) begin
         new_instr(1'b0, enq0_class, enq0_robid, enq0_src1, enq0_src2,
                   enq0_src1_busy, enq0_src2_busy, enq0_dest);
         enq0_valid = 1'b1;
      end
      if (n == 2 || (n == 1 && lane)) begin  // lone enq1 now and then
         new_instr(1'b0, enq1_class, enq1_robid, enq1_src1, enq1_src2,
                   enq1_src1_busy, enq1_src2_busy, enq1_dest);
         enq1_valid = 1'b1;
      end
      drive_wb(wb0_valid, wb0_tag);
      drive_wb(wb1_valid, wb1_tag);
      if (mul_left == 0) begin
         mul_busy = !mul_busy;
         mul_left = mul_busy ? $urandom_range(40, 10) : $urandom_range(8, 1);
      end else begin
         mul_left--;
      end
   endtask

   // the last credit is collected on the falling edge after the last issue
   task automatic drain(input bit active);
      while (live > 0) begin
         if (active)
            random_cycle(1'b0);
         else
            step();
      end
   endtask

   task automatic check_issue(input int slot, input iq_pkg::rob_id_t rid,
                              input iq_pkg::op_class_t cls,
                              input iq_pkg::prf_tag_t dst);
      assert (in_flight[rid]) else begin
         errors++;
         $display("slot %0d issued robid %h which is not in the queue", slot, rid);
      end
      assert (cls == exp_class[rid]) else begin
         errors++;
         $display("MISMATCH slot%0d_class robid %h expected %h got %h",
                  slot, rid, exp_class[rid], cls);
      end
      assert (dst == exp_dest[rid]) else begin
         errors++;
         $display("MISMATCH slot%0d_dest robid %h expected %h got %h",
                  slot, rid, exp_dest[rid], dst);
      end
      for (int s = 0; s < 2; s++) begin
         if (busy_has[rid][s])
            assert (wb_at[rid][s] >= 0 && wb_at[rid][s] < cyc) else begin
               errors++;
               $display("robid %h issued before tag %h was written back",
                        rid, busy_tag[rid][s]);
            end
      end
      in_flight[rid] = 1'b0;
      live--;
      issue_count++;
      if (directed)
         dir_log.push_back({slot[0], rid});
   endtask

   // outputs are stable just before the rising edge
   always @(posedge clk) begin
      cyc++;
      if (reset_n) begin
         if (enq_total == 0)
            assert (!slot0_valid && !slot1_valid && credit_return == 2'd0) else begin
               errors++;
               $display("MISMATCH idle slot0_valid=%h slot1_valid=%h credit_return=%h",
                        slot0_valid, slot1_valid, credit_return);
            end
         if (slot0_valid)
            check_issue(0, slot0_robid, slot0_class, slot0_dest);
         if (slot1_valid)
            check_issue(1, slot1_robid, slot1_class, slot1_dest);
      end
   end

   initial begin
      #((50 * TOTAL + 200) * 2 * CLK_HALF);
      $display("timeout after %0d cycles, the queue did not drain", cyc);
      $display("TEST FAIL");
      $finish;
   end

   initial begin
      void'($urandom(18384));
      reset_n  = 1'b0;
      mul_busy = 1'b0;
      {enq0_valid, enq0_class, enq0_robid, enq0_src1, enq0_src2} = '0;
      {enq0_src1_busy, enq0_src2_busy, enq0_dest} = '0;
      {enq1_valid, enq1_class, enq1_robid, enq1_src1, enq1_src2} = '0;
      {enq1_src1_busy, enq1_src2_busy, enq1_dest} = '0;
      {wb0_valid, wb0_tag, wb1_valid, wb1_tag} = '0;
      repeat (5) @(negedge clk);
      reset_n = 1'b1;
      repeat (3) step();

      // four ready ALU ops, two per cycle
      directed = 1'b1;
      repeat (2) begin
         step();
         new_instr(1'b1, enq0_class, enq0_robid, enq0_src1, enq0_src2,
                   enq0_src1_busy, enq0_src2_busy, enq0_dest);
         enq0_valid = 1'b1;
         new_instr(1'b1, enq1_class, enq1_robid, enq1_src1, enq1_src2,
                   enq1_src1_busy, enq1_src2_busy, enq1_dest);
         enq1_valid = 1'b1;
      end
      drain(1'b0);
      directed = 1'b0;
      assert (dir_log.size() == 4) else begin
         errors++;
         $display("directed phase issued %0d instructions instead of 4", dir_log.size());
      end
      foreach (dir_log[i])
         assert (dir_log[i] == {i[0], dir_exp[i]}) else begin
            errors++;
            $display("MISMATCH directed issue %0d {slot,robid} expected %h got %h",
                     i, {i[0], dir_exp[i]}, dir_log[i]);
         end

      while (enq_total < TOTAL)
         random_cycle(1'b1);
      drain(1'b1);

      assert (returned == enq_total) else begin
         errors++;
         $display("MISMATCH credit_return sum expected %h got %h", enq_total, returned);
      end

      $display("%0d scoreboard errors, %0d assertion failures, %0d enqueued, %0d issued",
               errors, dut.u_props.fail_count, enq_total, issue_count);
      if (errors == 0 && dut.u_props.fail_count == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// File: tb.f
logic/iq_pkg.sv
logic/iq_ifs.sv
logic/free_slot_finder.sv
logic/entry_array.sv
logic/age_tracker.sv
logic/oldest_picker.sv
logic/slot_steer.sv
logic/issue_queue_top.sv
verif/issue_queue_properties.sv
verif/tb_issue_queue.sv
